//--- design/issueQueue_macros.svh
`ifndef ISSUEQUEUE_MACROS_SVH
`define ISSUEQUEUE_MACROS_SVH

// Queue entries
`define IQ_SIZE 8

// Physical register tag, all ones means no destination
`define TAG_BITS 6

// Sequence numbers wrap, age by signed difference
`define SQN_BITS 6

// Edges from issue to result broadcast
`define EXEC_LATENCY 3

// Cycles a slow op blocks further issue
`define SLOW_BUSY 4

`endif

//--- design/uopPkg.sv
`include "issueQueue_macros.svh"

package uopPkg;

    typedef logic [`TAG_BITS-1:0] Tag_t;
    typedef logic [`SQN_BITS-1:0] SqN_t;

    // FU_OTHER is served by another port
    typedef enum logic [1:0] {
        FU_ALU,
        FU_SLOW,
        FU_ST,
        FU_OTHER
    } FuncUnit_t;

    typedef struct packed {
        logic [1:0] pad;
        Tag_t       tag;
    } SrcBTag_t;

    typedef logic [`TAG_BITS+1:0] SrcBImm_t;

    // Operand B, meaning picked by immB
    typedef union packed {
        SrcBTag_t asTag;
        SrcBImm_t asImm;
    } SrcB_u;

    typedef struct packed {
        logic      valid;
        FuncUnit_t fu;
        SqN_t      sqN;
        SqN_t      storeSqN;
        Tag_t      tagDst;
        Tag_t      tagA;
        logic      availA;
        logic      immB;
        SrcB_u     srcB;
        logic      availB;
    } DispatchUop_t;

    typedef struct packed {
        logic      valid;
        FuncUnit_t fu;
        SqN_t      sqN;
        SqN_t      storeSqN;
        Tag_t      tagDst;
        Tag_t      tagA;
        logic      immB;
        SrcB_u     srcB;
    } IssueUop_t;

endpackage

//--- design/schedPkg.sv
package schedPkg;

    import uopPkg::*;

    typedef struct packed {
        logic taken;
        SqN_t sqN;
    } BranchFlush_t;

    typedef struct packed {
        logic valid;
        Tag_t tagDst;
        SqN_t sqN;
    } ResultMsg_t;

    // True when a was dispatched after b, wrap-safe
    function automatic logic isYounger(SqN_t a, SqN_t b);
        SqN_t diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

endpackage

//--- design/schedIfs.sv
`timescale 1ns/1ps

// Result broadcast, fire and forget
interface resultBusIf
    import schedPkg::*;
();

    ResultMsg_t msg;

    modport producer (
        output msg
    );

    modport listener (
        input msg
    );

endinterface

// Queue to functional unit
// uop.valid is taken unconditionally, stall only throttles the next select
interface issuePortIf
    import uopPkg::*;
();

    IssueUop_t uop;
    logic      stall;

    modport issuer (
        output uop,
        input  stall
    );

    modport unit (
        input  uop,
        output stall
    );

endinterface

//--- design/wakeupMatch.sv
`timescale 1ns/1ps
`include "issueQueue_macros.svh"

module wakeupMatch
    import uopPkg::*;
(
    input  Tag_t  entryTagA [`IQ_SIZE],
    input  SrcB_u entrySrcB [`IQ_SIZE],
    input  logic  entryImmB [`IQ_SIZE],
    resultBusIf.listener res,
    input  logic  loadFwdValid,
    input  Tag_t  loadFwdTag,
    output logic  wakeA [`IQ_SIZE],
    output logic  wakeB [`IQ_SIZE]
);

    logic resHitA;
    logic resHitB;
    logic fwdHitA;
    logic fwdHitB;

    always_comb begin
        for (int i = 0; i < `IQ_SIZE; i++) begin
            resHitA = res.msg.valid && (entryTagA[i] == res.msg.tagDst);
            fwdHitA = loadFwdValid && (entryTagA[i] == loadFwdTag);
            wakeA[i] = resHitA || fwdHitA;

            // Immediate operands never wait on a tag
            resHitB = res.msg.valid && (entrySrcB[i].asTag.tag == res.msg.tagDst);
            fwdHitB = loadFwdValid && (entrySrcB[i].asTag.tag == loadFwdTag);
            wakeB[i] = !entryImmB[i] && (resHitB || fwdHitB);
        end
    end

endmodule

//--- design/issueQueue.sv
`timescale 1ns/1ps
`include "issueQueue_macros.svh"

module issueQueue
    import uopPkg::*, schedPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         frontEn,
    input  DispatchUop_t dispatchUop0,
    input  DispatchUop_t dispatchUop1,
    input  BranchFlush_t flush,
    input  SqN_t         maxStoreSqN,
    input  logic         loadFwdValid,
    input  Tag_t         loadFwdTag,
    resultBusIf.listener res,
    issuePortIf.issuer   port,
    output logic         full
);

    localparam int idxW = $clog2(`IQ_SIZE);

    // Age ordered, index 0 is the oldest
    DispatchUop_t queue [`IQ_SIZE];
    DispatchUop_t qMerged [`IQ_SIZE];
    DispatchUop_t queueNext [`IQ_SIZE];
    logic [idxW:0] insertIndex;
    logic [idxW:0] idxNext;
    logic [idxW:0] numIn;

    Tag_t  entTagA [`IQ_SIZE];
    SrcB_u entSrcB [`IQ_SIZE];
    logic  entImmB [`IQ_SIZE];
    logic  wakeA [`IQ_SIZE];
    logic  wakeB [`IQ_SIZE];
    logic  ready [`IQ_SIZE];

    logic keep0;
    logic keep1;
    logic found;
    logic [idxW-1:0] selIdx;
    IssueUop_t issueNext;

    // Dispatch with this cycle's broadcast and load forward folded in
    function automatic DispatchUop_t enterUop(DispatchUop_t d, ResultMsg_t r,
                                              logic lfv, Tag_t lft);
        DispatchUop_t e;
        e = d;
        if ((r.valid && d.tagA == r.tagDst) || (lfv && d.tagA == lft))
            e.availA = 1'b1;
        if (d.immB)
            e.availB = 1'b1;
        else if ((r.valid && d.srcB.asTag.tag == r.tagDst) ||
                 (lfv && d.srcB.asTag.tag == lft))
            e.availB = 1'b1;
        return e;
    endfunction

    function automatic IssueUop_t toIssue(DispatchUop_t d);
        IssueUop_t u;
        u.valid = 1'b1;
        u.fu = d.fu;
        u.sqN = d.sqN;
        u.storeSqN = d.storeSqN;
        u.tagDst = d.tagDst;
        u.tagA = d.tagA;
        u.immB = d.immB;
        u.srcB = d.srcB;
        return u;
    endfunction

    always_comb begin
        for (int i = 0; i < `IQ_SIZE; i++) begin
            entTagA[i] = queue[i].tagA;
            entSrcB[i] = queue[i].srcB;
            entImmB[i] = queue[i].immB;
        end
    end

    wakeupMatch u_wakeup (
        .entryTagA   (entTagA),
        .entrySrcB   (entSrcB),
        .entryImmB   (entImmB),
        .res         (res),
        .loadFwdValid(loadFwdValid),
        .loadFwdTag  (loadFwdTag),
        .wakeA       (wakeA),
        .wakeB       (wakeB)
    );

    // Slots meant for this port
    assign keep0 = dispatchUop0.valid && (dispatchUop0.fu != FU_OTHER);
    assign keep1 = dispatchUop1.valid && (dispatchUop1.fu != FU_OTHER);
    assign numIn = (idxW + 1)'(keep0) + (idxW + 1)'(keep1);
    assign full = (insertIndex + numIn) > `IQ_SIZE;

    // Oldest ready entry
    always_comb begin
        found = 1'b0;
        selIdx = '0;
        for (int i = 0; i < `IQ_SIZE; i++) begin
            qMerged[i] = queue[i];
            qMerged[i].availA = queue[i].availA | wakeA[i];
            qMerged[i].availB = queue[i].availB | wakeB[i];
            ready[i] = (i < insertIndex) && qMerged[i].availA && qMerged[i].availB &&
                       !(queue[i].fu == FU_ST && isYounger(queue[i].storeSqN, maxStoreSqN));
            if (ready[i] && !found) begin
                found = 1'b1;
                selIdx = idxW'(i);
            end
        end
    end

    always_comb begin
        queueNext = qMerged;
        idxNext = insertIndex;
        issueNext = '0;
        if (flush.taken) begin
            // Younger entries sit on top, drop them by moving the insert index
            idxNext = '0;
            for (int i = 0; i < `IQ_SIZE; i++) begin
                if (i < insertIndex && !isYounger(queue[i].sqN, flush.sqN))
                    idxNext = (idxW + 1)'(i + 1);
            end
        end else begin
            if (found && !port.stall) begin
                issueNext = toIssue(queue[selIdx]);
                for (int j = 0; j < `IQ_SIZE - 1; j++) begin
                    if (j >= selIdx)
                        queueNext[j] = qMerged[j + 1];
                end
                idxNext = insertIndex - 1'b1;
            end
            if (frontEn && !full) begin
                if (keep0) begin
                    queueNext[idxNext[idxW-1:0]] =
                        enterUop(dispatchUop0, res.msg, loadFwdValid, loadFwdTag);
                    idxNext = idxNext + 1'b1;
                end
                if (keep1) begin
                    queueNext[idxNext[idxW-1:0]] =
                        enterUop(dispatchUop1, res.msg, loadFwdValid, loadFwdTag);
                    idxNext = idxNext + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        queue <= queueNext;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            insertIndex <= '0;
            port.uop.valid <= 1'b0;
        end else begin
            insertIndex <= idxNext;
            port.uop <= issueNext;
        end
    end

endmodule

//--- design/execPipe.sv
`timescale 1ns/1ps
`include "issueQueue_macros.svh"

module execPipe
    import uopPkg::*, schedPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    issuePortIf.unit     port,
    input  BranchFlush_t flush,
    resultBusIf.producer res
);

    localparam int lastStage = `EXEC_LATENCY - 1;
    localparam int busyW = $clog2(`SLOW_BUSY + 1);

    logic stValid [`EXEC_LATENCY];
    Tag_t stTag [`EXEC_LATENCY];
    SqN_t stSqN [`EXEC_LATENCY];
    logic [busyW-1:0] busyCnt;

    function automatic logic squashed(SqN_t s, BranchFlush_t f);
        return f.taken && isYounger(s, f.sqN);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int k = 0; k < `EXEC_LATENCY; k++)
                stValid[k] <= 1'b0;
        end else begin
            stValid[0] <= port.uop.valid && !squashed(port.uop.sqN, flush);
            for (int k = 1; k < `EXEC_LATENCY; k++)
                stValid[k] <= stValid[k - 1] && !squashed(stSqN[k - 1], flush);
        end
    end

    always_ff @(posedge clk) begin
        stTag[0] <= port.uop.tagDst;
        stSqN[0] <= port.uop.sqN;
        for (int k = 1; k < `EXEC_LATENCY; k++) begin
            stTag[k] <= stTag[k - 1];
            stSqN[k] <= stSqN[k - 1];
        end
    end

    // Slow op occupies the unit and holds off the queue
    always_ff @(posedge clk) begin
        if (rst)
            busyCnt <= '0;
        else if (port.uop.valid && port.uop.fu == FU_SLOW)
            busyCnt <= busyW'(`SLOW_BUSY);
        else if (busyCnt != '0)
            busyCnt <= busyCnt - 1'b1;
    end

    assign port.stall = (busyCnt != '0);

    // No broadcast for ops without a destination
    assign res.msg.valid = stValid[lastStage] && (stTag[lastStage] != '1) &&
                           !squashed(stSqN[lastStage], flush);
    assign res.msg.tagDst = stTag[lastStage];
    assign res.msg.sqN = stSqN[lastStage];

endmodule

//--- design/issueCluster.sv
`timescale 1ns/1ps

module issueCluster
    import uopPkg::*, schedPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         frontEn,
    input  DispatchUop_t dispatchUop0,
    input  DispatchUop_t dispatchUop1,
    input  logic         branchTaken,
    input  SqN_t         branchSqN,
    input  SqN_t         maxStoreSqN,
    input  logic         loadFwdValid,
    input  Tag_t         loadFwdTag,
    output logic         full,
    output logic         resultValid,
    output Tag_t         resultTag,
    output SqN_t         resultSqN,
    output logic         issueValid,
    output SqN_t         issueSqN
);

    BranchFlush_t flush;

    resultBusIf resBus ();
    issuePortIf issPort ();

    assign flush.taken = branchTaken;
    assign flush.sqN = branchSqN;

    issueQueue u_queue (
        .clk         (clk),
        .rst         (rst),
        .frontEn     (frontEn),
        .dispatchUop0(dispatchUop0),
        .dispatchUop1(dispatchUop1),
        .flush       (flush),
        .maxStoreSqN (maxStoreSqN),
        .loadFwdValid(loadFwdValid),
        .loadFwdTag  (loadFwdTag),
        .res         (resBus.listener),
        .port        (issPort.issuer),
        .full        (full)
    );

    execPipe u_pipe (
        .clk  (clk),
        .rst  (rst),
        .port (issPort.unit),
        .flush(flush),
        .res  (resBus.producer)
    );

    // Observation of issue and broadcast
    assign issueValid = issPort.uop.valid;
    assign issueSqN = issPort.uop.sqN;
    assign resultValid = resBus.msg.valid;
    assign resultTag = resBus.msg.tagDst;
    assign resultSqN = resBus.msg.sqN;

endmodule

//--- verification/issueQueue_sva.sv
`timescale 1ns/1ps

module issueQueue_sva (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic issueValid,
    input logic flushTaken,
    input logic full
);

    // Stall in the select cycle blocks the next issue
    stallBlocksIssue: assert property (@(posedge clk) disable iff (rst)
        stall |=> !issueValid) else $error("issue in the cycle after stall was high");

    fullLowAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !full) else $error("full is high right after reset");

    flushClearsIssue: assert property (@(posedge clk) disable iff (rst)
        flushTaken |=> !issueValid) else $error("issue in the cycle after a flush");

endmodule

bind issueQueue issueQueue_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .stall     (port.stall),
    .issueValid(port.uop.valid),
    .flushTaken(flush.taken),
    .full      (full)
);

//--- verification/tbIssueCluster.sv
`timescale 1ns/1ps
`include "issueQueue_macros.svh"

module tbIssueCluster
    import uopPkg::*;
();

    localparam int pairsPerTest = 60;
    localparam int cycleLimit = 3 * pairsPerTest * 2 *
                                (`IQ_SIZE + `SLOW_BUSY + `EXEC_LATENCY) + 500;

    logic clk, rst, frontEn, branchTaken, loadFwdValid;
    logic full, resultValid, issueValid;
    DispatchUop_t dispatchUop0, dispatchUop1;
    SqN_t branchSqN, maxStoreSqN, resultSqN, issueSqN;
    Tag_t loadFwdTag, resultTag;

    // Reference model indexed by sequence number
    bit live [64];
    bit issued [64];
    FuncUnit_t fuOf [64];
    Tag_t dstOf [64];
    Tag_t srcAOf [64];
    Tag_t srcBOf [64];
    SqN_t stqOf [64];
    int rdyA [64];
    int rdyB [64];
    int dispCyc [64];
    int issCyc [64];
    bit tagBusy [64];

    int cyc = 0;
    int errors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int liveCount = 0;
    int pairsSent = 0;
    int quietFrom = -10;
    int quietTo = -10;
    int timeCnt = 0;
    bit havePair = 0;
    SqN_t nextSq = '0;
    SqN_t stCount = '0;
    SqN_t bound = '0;
    SqN_t boundSel = '0;
    Tag_t nextTag = '0;

    issueCluster u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        timeCnt++;
        if (timeCnt > cycleLimit) begin
            $display("timeout: run exceeded the limit of %0d cycles", cycleLimit);
            $display("tests failed");
            $finish;
        end
    end

    // True when a was dispatched after b even across a wrap
    function automatic bit newer(SqN_t a, SqN_t b);
        SqN_t d;
        d = a - b;
        return (d != 0) && !d[`SQN_BITS-1];
    endfunction

    // Slots this port accepts
    function automatic int kept(DispatchUop_t u);
        return (u.valid && u.fu != FU_OTHER) ? 1 : 0;
    endfunction

    task automatic checkThat(bit cond, string msg);
        assert (cond) else begin
            $display("CHECK FAILED at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    task automatic makeUop(output DispatchUop_t u);
        int r;
        r = $urandom_range(0, 9);
        u = '0;
        u.valid = $urandom_range(0, 7) != 0;
        u.fu = (r < 5) ? FU_ALU : (r < 7) ? FU_SLOW : (r < 9) ? FU_ST : FU_OTHER;
        u.sqN = nextSq;
        nextSq++;
        u.storeSqN = stCount;
        if (u.valid && u.fu == FU_ST)
            stCount++;
        // Sources first so an op never waits on itself
        u.tagA = Tag_t'($urandom_range(0, 62));
        u.availA = !tagBusy[u.tagA];
        u.immB = $urandom_range(0, 3) == 0;
        if (u.immB) begin
            u.srcB.asImm = SrcBImm_t'($urandom);
            u.availB = 1'b1;
        end else begin
            u.srcB.asTag.tag = Tag_t'($urandom_range(0, 62));
            u.availB = !tagBusy[u.srcB.asTag.tag];
        end
        u.tagDst = '1;
        if (u.valid && u.fu != FU_OTHER && u.fu != FU_ST && $urandom_range(0, 5) != 0) begin
            while (tagBusy[nextTag] || nextTag == '1)
                nextTag++;
            u.tagDst = nextTag;
            tagBusy[nextTag] = 1'b1;
            nextTag++;
        end
    endtask

    task automatic addLive(DispatchUop_t u);
        if (u.valid && u.fu != FU_OTHER) begin
            live[u.sqN] = 1'b1;
            issued[u.sqN] = 1'b0;
            fuOf[u.sqN] = u.fu;
            dstOf[u.sqN] = u.tagDst;
            srcAOf[u.sqN] = u.tagA;
            srcBOf[u.sqN] = u.srcB.asTag.tag;
            stqOf[u.sqN] = u.storeSqN;
            rdyA[u.sqN] = u.availA ? cyc : -1;
            rdyB[u.sqN] = (u.immB || u.availB) ? cyc : -1;
            dispCyc[u.sqN] = cyc;
            liveCount++;
        end
    endtask

    task automatic retire(int i);
        live[i] = 1'b0;
        if (dstOf[i] != '1)
            tagBusy[dstOf[i]] = 1'b0;
        liveCount--;
    endtask

    task automatic dropPair();
        if (dispatchUop0.tagDst != '1)
            tagBusy[dispatchUop0.tagDst] = 1'b0;
        if (dispatchUop1.tagDst != '1)
            tagBusy[dispatchUop1.tagDst] = 1'b0;
    endtask

    task automatic wakeTag(Tag_t t);
        for (int i = 0; i < 64; i++) begin
            if (live[i] && !issued[i] && rdyA[i] < 0 && srcAOf[i] == t)
                rdyA[i] = cyc;
            if (live[i] && !issued[i] && rdyB[i] < 0 && srcBOf[i] == t)
                rdyB[i] = cyc;
        end
    endtask

    // A pair held back by full picks up the wakeups the queue did not see
    function automatic DispatchUop_t refreshUop(DispatchUop_t u);
        DispatchUop_t r;
        r = u;
        if (!tagBusy[u.tagA] || (loadFwdValid && u.tagA == loadFwdTag))
            r.availA = 1'b1;
        if (!tagBusy[u.srcB.asTag.tag] ||
            (loadFwdValid && u.srcB.asTag.tag == loadFwdTag))
            r.availB = 1'b1;
        return r;
    endfunction

    // Sample the cycle that just ended before this edge's updates land
    task automatic sampleCycle();
        SqN_t s;
        int occ;
        cyc++;
        occ = 0;
        for (int i = 0; i < 64; i++)
            if (live[i] && !issued[i])
                occ++;
        // The entry on the issue port already left the queue
        if (issueValid && live[issueSqN] && !issued[issueSqN])
            occ--;
        checkThat(full == (occ + kept(dispatchUop0) + kept(dispatchUop1) > `IQ_SIZE),
                  $sformatf("full is %0b with %0d entries queued", full, occ));
        if (frontEn && !full && !branchTaken) begin
            addLive(dispatchUop0);
            addLive(dispatchUop1);
            havePair = 0;
            pairsSent++;
        end
        if (issueValid) begin
            s = issueSqN;
            checkThat(cyc < quietFrom || cyc > quietTo, "issue during slow-op busy time");
            checkThat(live[s] && !issued[s], $sformatf("issue of unexpected sqN %0d", s));
            if (live[s] && !issued[s]) begin
                checkThat(dispCyc[s] <= cyc - 2, $sformatf("sqN %0d issued too early", s));
                checkThat(rdyA[s] >= 0 && rdyA[s] < cyc, $sformatf("sqN %0d operand A", s));
                checkThat(rdyB[s] >= 0 && rdyB[s] < cyc, $sformatf("sqN %0d operand B", s));
                if (fuOf[s] == FU_ST)
                    checkThat(!newer(stqOf[s], boundSel), $sformatf("store %0d past bound", s));
                issued[s] = 1'b1;
                issCyc[s] = cyc;
                if (fuOf[s] == FU_SLOW) begin
                    quietFrom = (quietTo >= cyc) ? quietFrom : cyc + 2;
                    quietTo = cyc + `SLOW_BUSY + 1;
                end
                if (dstOf[s] == '1)
                    retire(s);
            end
        end
        if (resultValid) begin
            s = resultSqN;
            checkThat(live[s] && issued[s] && dstOf[s] == resultTag &&
                      cyc == issCyc[s] + `EXEC_LATENCY,
                      $sformatf("unexpected broadcast sqN %0d tag %0d", s, resultTag));
            if (live[s] && issued[s])
                retire(s);
            wakeTag(resultTag);
        end
        if (loadFwdValid)
            wakeTag(loadFwdTag);
        if (branchTaken) begin
            for (int i = 0; i < 64; i++)
                if (live[i] && newer(SqN_t'(i), branchSqN))
                    retire(i);
        end
        for (int i = 0; i < 64; i++) begin
            if (live[i] && issued[i] && cyc > issCyc[i] + `EXEC_LATENCY) begin
                checkThat(1'b0, $sformatf("no broadcast for sqN %0d", i));
                retire(i);
            end
        end
        if (havePair) begin
            dispatchUop0 <= refreshUop(dispatchUop0);
            dispatchUop1 <= refreshUop(dispatchUop1);
        end
        boundSel = maxStoreSqN;
    endtask

    task automatic driveNext(int pairs, int flushOdds, int fwdOdds);
        DispatchUop_t u0, u1;
        bit fl;
        Tag_t ft;
        fl = pairsSent < pairs && !branchTaken && $urandom_range(1, flushOdds) == 1;
        if (fl) begin
            if (havePair)
                dropPair();
            havePair = 0;
            branchSqN <= nextSq - SqN_t'($urandom_range(1, 7));
        end else if (!havePair && pairsSent < pairs && liveCount <= 12) begin
            makeUop(u0);
            makeUop(u1);
            dispatchUop0 <= u0;
            dispatchUop1 <= u1;
            havePair = 1;
        end
        branchTaken <= fl;
        frontEn <= havePair && !fl;
        ft = Tag_t'($urandom_range(0, 62));
        loadFwdValid <= tagBusy[ft] && $urandom_range(1, fwdOdds) == 1;
        loadFwdTag <= ft;
        // Store bound creeps up, and opens fully while draining
        if (pairsSent >= pairs)
            bound = stCount;
        else if (bound != stCount && $urandom_range(0, 2) == 0)
            bound++;
        maxStoreSqN <= bound;
    endtask

    task automatic report(string name, int errBefore);
        testsRun++;
        if (errors == errBefore) begin
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: FAILED", name);
        end
    endtask

    task automatic runTraffic(string name, int flushOdds, int fwdOdds);
        int errBefore;
        int quiet;
        errBefore = errors;
        pairsSent = 0;
        quiet = 0;
        while (quiet < `EXEC_LATENCY + 4) begin
            @(posedge clk);
            sampleCycle();
            if (pairsSent >= pairsPerTest && !havePair && liveCount == 0)
                quiet++;
            else
                quiet = 0;
            driveNext(pairsPerTest, flushOdds, fwdOdds);
        end
        report(name, errBefore);
    endtask

    initial begin
        int errBefore;
        void'($urandom(32'hbe07_06aa));
        rst = 1'b1;
        frontEn = 1'b0;
        dispatchUop0 = '0;
        dispatchUop1 = '0;
        branchTaken = 1'b0;
        branchSqN = '0;
        maxStoreSqN = '0;
        loadFwdValid = 1'b0;
        loadFwdTag = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        errBefore = errors;
        @(posedge clk);
        @(posedge clk);
        checkThat(!issueValid && !resultValid && !full, "outputs not idle after reset");
        report("reset state", errBefore);
        runTraffic("mixed traffic", 40, 12);
        runTraffic("frequent flush", 6, 12);
        runTraffic("load forward", 50, 3);
        $display("tests run: %0d, failing: %0d, check errors: %0d",
                 testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
design/uopPkg.sv
design/schedPkg.sv
design/schedIfs.sv
design/wakeupMatch.sv
design/issueQueue.sv
design/execPipe.sv
design/issueCluster.sv
verification/issueQueue_sva.sv
verification/tbIssueCluster.sv

//--- Makefile
TOP = tbIssueCluster

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
